/* decodeTop.f */
hw/cpuPkg.sv
hw/instrControl.sv
hw/aluControl.sv
hw/regFileBypass.sv
hw/destPipeline.sv
hw/decodeStage.sv
hw/decodeTop.sv
testbench/clockGen.sv
testbench/tb_decodeTop.sv

/* hw/aluControl.sv */
// Turns the ALU class and the function field into the ALU op and operand bits
// Subtraction inverts A and sets carry-in, ANDN inverts B
`timescale 1ns/1ps

module aluControl (
    input  cpuPkg::aluClassT aluClass,
    input  logic [1:0]       func,
    output cpuPkg::aluOpT    aluOp,
    output logic             invA,
    output logic             invB,
    output logic             cin
);
    import cpuPkg::*;

    always_comb begin
        aluOp = aluPass;
        invA  = 1'b0;
        invB  = 1'b0;
        cin   = 1'b0;

        case (aluClass)
            classRrr: begin
                // Function field selects add, sub, xor or andn
                case (func)
                    2'b00: aluOp = aluAdd;
                    2'b01: begin
                        aluOp = aluAdd;
                        invA  = 1'b1;
                        cin   = 1'b1;
                    end
                    2'b10: aluOp = aluXor;
                    default: begin
                        aluOp = aluAnd;
                        invB  = 1'b1;
                    end
                endcase
            end
            classAddi, classAddr: aluOp = aluAdd;
            classSubi: begin
                aluOp = aluAdd;
                invA  = 1'b1;
                cin   = 1'b1;
            end
            classXori: aluOp = aluXor;
            classAndni: begin
                aluOp = aluAnd;
                invB  = 1'b1;
            end
            default: aluOp = aluPass;
        endcase
    end

endmodule

/* hw/cpuPkg.sv */
// Widths and encodings shared by the decode stage modules
// Imported by each RTL module and by the testbench
package cpuPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;

    // Major opcodes, instruction bits 15 to 11
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opLbi   = 5'b11000,
        opRrr   = 5'b11011
    } opcodeT;

    // Sub is add with invA and cin, andn is and with invB
    typedef enum logic [1:0] {
        aluAdd  = 2'd0,
        aluXor  = 2'd1,
        aluAnd  = 2'd2,
        aluPass = 2'd3
    } aluOpT;

    typedef enum logic [2:0] {
        classRrr   = 3'd0,
        classAddi  = 3'd1,
        classSubi  = 3'd2,
        classXori  = 3'd3,
        classAndni = 3'd4,
        classPass  = 3'd5,
        classAddr  = 3'd6
    } aluClassT;

    // Which instruction field names the destination
    typedef enum logic [1:0] {
        dstRd   = 2'd0,
        dstRt   = 2'd1,
        dstRs   = 2'd2,
        dstLink = 2'd3
    } dstSelT;

    typedef enum logic [1:0] {
        srcAlu = 2'd0,
        srcMem = 2'd1,
        srcPc  = 2'd2,
        srcImm = 2'd3
    } regSrcT;

    typedef enum logic [1:0] {
        bReg  = 2'd0,
        bImm5 = 2'd1,
        bImm8 = 2'd2
    } bSrcT;

    typedef enum logic [1:0] {
        brNone = 2'd0,
        brEqz  = 2'd1,
        brNez  = 2'd2,
        brJump = 2'd3
    } branchT;

endpackage

/* hw/decodeStage.sv */
// Forces NOPs, selects the destination, extends immediates and registers the
// decode results toward execute
`timescale 1ns/1ps

module decodeStage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            nopInsert,
    input  logic [cpuPkg::dataWidth-1:0]    instr,
    input  logic [cpuPkg::dataWidth-1:0]    pc,
    output logic [cpuPkg::dataWidth-1:0]    instrDec,
    // Combinational control and ALU levels
    input  cpuPkg::dstSelT                  dstSel,
    input  logic                            regWriteRaw,
    input  logic                            zeroExt,
    input  cpuPkg::bSrcT                    bSrcRaw,
    input  cpuPkg::regSrcT                  regSrcRaw,
    input  logic                            memReadRaw,
    input  logic                            memWriteRaw,
    input  cpuPkg::branchT                  branchRaw,
    input  logic                            haltRaw,
    input  cpuPkg::aluOpT                   aluOpRaw,
    input  logic                            invARaw,
    input  logic                            invBRaw,
    input  logic                            cinRaw,
    input  logic [cpuPkg::dataWidth-1:0]    rsIn,
    input  logic [cpuPkg::dataWidth-1:0]    rtIn,
    // Registered toward execute
    output cpuPkg::aluOpT                   aluOp,
    output logic                            invA,
    output logic                            invB,
    output logic                            cin,
    output cpuPkg::bSrcT                    bSrc,
    output logic                            memRead,
    output logic                            memWrite,
    output cpuPkg::branchT                  branch,
    output logic                            halt,
    output logic [cpuPkg::dataWidth-1:0]    rsData,
    output logic [cpuPkg::dataWidth-1:0]    rtData,
    output logic [cpuPkg::dataWidth-1:0]    imm5,
    output logic [cpuPkg::dataWidth-1:0]    imm8,
    output logic [cpuPkg::dataWidth-1:0]    simm11,
    output logic [cpuPkg::dataWidth-1:0]    pcNext,
    output logic [cpuPkg::regAddrWidth-1:0] rd,
    output logic                            regWrite,
    output cpuPkg::regSrcT                  regSrc
);
    import cpuPkg::*;

    logic [regAddrWidth-1:0] rdSel;
    logic [dataWidth-1:0]    imm5Ext;
    logic [dataWidth-1:0]    imm8Ext;
    logic [dataWidth-1:0]    simm11Ext;

    // Bubble from the stall controller
    assign instrDec = nopInsert ? {opNop, {(dataWidth-5){1'b0}}} : instr;

    always_comb begin
        case (dstSel)
            dstRd:   rdSel = instrDec[4:2];
            dstRt:   rdSel = instrDec[7:5];
            dstRs:   rdSel = instrDec[10:8];
            default: rdSel = '1;
        endcase
    end

    assign imm5Ext   = zeroExt ? {{(dataWidth-5){1'b0}}, instrDec[4:0]}
                               : {{(dataWidth-5){instrDec[4]}}, instrDec[4:0]};
    assign imm8Ext   = zeroExt ? {{(dataWidth-8){1'b0}}, instrDec[7:0]}
                               : {{(dataWidth-8){instrDec[7]}}, instrDec[7:0]};
    assign simm11Ext = {{(dataWidth-11){instrDec[10]}}, instrDec[10:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            aluOp    <= aluAdd;
            invA     <= 1'b0;
            invB     <= 1'b0;
            cin      <= 1'b0;
            bSrc     <= bReg;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            branch   <= brNone;
            halt     <= 1'b0;
            rsData   <= '0;
            rtData   <= '0;
            imm5     <= '0;
            imm8     <= '0;
            simm11   <= '0;
            pcNext   <= '0;
            rd       <= '0;
            regWrite <= 1'b0;
            regSrc   <= srcAlu;
        end else begin
            aluOp    <= aluOpRaw;
            invA     <= invARaw;
            invB     <= invBRaw;
            cin      <= cinRaw;
            bSrc     <= bSrcRaw;
            memRead  <= memReadRaw;
            memWrite <= memWriteRaw;
            branch   <= branchRaw;
            halt     <= haltRaw;
            rsData   <= rsIn;
            rtData   <= rtIn;
            imm5     <= imm5Ext;
            imm8     <= imm8Ext;
            simm11   <= simm11Ext;
            pcNext   <= pc;
            rd       <= rdSel;
            regWrite <= regWriteRaw;
            regSrc   <= regSrcRaw;
        end
    end

    // Load and store never share a decoded instruction
    assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
        else $error("memRead and memWrite both active");

endmodule

/* hw/decodeTop.sv */
// Decode stage top level, connects control decode, register file and pipelines
// Write-back uses the last destination stage together with wbData
`timescale 1ns/1ps

module decodeTop #(
    parameter int pipeDepth = 3,
    parameter int numRegs   = 8
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [cpuPkg::dataWidth-1:0]                   instr,
    input  logic [cpuPkg::dataWidth-1:0]                   pc,
    input  logic                                           nopInsert,
    input  logic [cpuPkg::dataWidth-1:0]                   wbData,
    output cpuPkg::aluOpT                                  aluOp,
    output logic                                           invA,
    output logic                                           invB,
    output logic                                           cin,
    output cpuPkg::bSrcT                                   bSrc,
    output logic                                           memRead,
    output logic                                           memWrite,
    output cpuPkg::branchT                                 branch,
    output logic                                           halt,
    output logic [cpuPkg::dataWidth-1:0]                   rsData,
    output logic [cpuPkg::dataWidth-1:0]                   rtData,
    output logic [cpuPkg::dataWidth-1:0]                   imm5,
    output logic [cpuPkg::dataWidth-1:0]                   imm8,
    output logic [cpuPkg::dataWidth-1:0]                   simm11,
    output logic [cpuPkg::dataWidth-1:0]                   pcNext,
    output logic [pipeDepth-1:0][cpuPkg::regAddrWidth-1:0] rdStages,
    output logic [pipeDepth-1:0]                           regWriteStages,
    output cpuPkg::regSrcT                                 regSrc
);
    import cpuPkg::*;

    logic [dataWidth-1:0]    instrDec;
    aluClassT                aluClass;
    dstSelT                  dstSel;
    logic                    regWriteRaw;
    logic                    zeroExt;
    bSrcT                    bSrcRaw;
    regSrcT                  regSrcRaw;
    logic                    memReadRaw;
    logic                    memWriteRaw;
    branchT                  branchRaw;
    logic                    haltRaw;
    aluOpT                   aluOpRaw;
    logic                    invARaw;
    logic                    invBRaw;
    logic                    cinRaw;
    logic [dataWidth-1:0]    rsRead;
    logic [dataWidth-1:0]    rtRead;
    logic [regAddrWidth-1:0] rdDec;
    logic                    regWriteDec;
    regSrcT                  regSrcDec;
    logic [regAddrWidth-1:0] wbRd;
    logic                    wbRegWrite;

    // Write-back stage of the destination pipeline
    assign wbRd       = rdStages[pipeDepth-1];
    assign wbRegWrite = regWriteStages[pipeDepth-1];

    instrControl instrControl_i (
        .opcode   (opcodeT'(instrDec[15:11])),
        .aluClass (aluClass),
        .dstSel   (dstSel),
        .regWrite (regWriteRaw),
        .zeroExt  (zeroExt),
        .memRead  (memReadRaw),
        .memWrite (memWriteRaw),
        .halt     (haltRaw),
        .bSrc     (bSrcRaw),
        .regSrc   (regSrcRaw),
        .branch   (branchRaw)
    );

    aluControl aluControl_i (
        .aluClass (aluClass),
        .func     (instrDec[1:0]),
        .aluOp    (aluOpRaw),
        .invA     (invARaw),
        .invB     (invBRaw),
        .cin      (cinRaw)
    );

    regFileBypass #(
        .numRegs (numRegs)
    ) regFileBypass_i (
        .clk       (clk),
        .reset     (reset),
        .readSel1  (instrDec[10:8]),
        .readSel2  (instrDec[7:5]),
        .writeSel  (wbRd),
        .writeData (wbData),
        .writeEn   (wbRegWrite),
        .readData1 (rsRead),
        .readData2 (rtRead)
    );

    decodeStage decodeStage_i (
        .clk         (clk),
        .reset       (reset),
        .nopInsert   (nopInsert),
        .instr       (instr),
        .pc          (pc),
        .instrDec    (instrDec),
        .dstSel      (dstSel),
        .regWriteRaw (regWriteRaw),
        .zeroExt     (zeroExt),
        .bSrcRaw     (bSrcRaw),
        .regSrcRaw   (regSrcRaw),
        .memReadRaw  (memReadRaw),
        .memWriteRaw (memWriteRaw),
        .branchRaw   (branchRaw),
        .haltRaw     (haltRaw),
        .aluOpRaw    (aluOpRaw),
        .invARaw     (invARaw),
        .invBRaw     (invBRaw),
        .cinRaw      (cinRaw),
        .rsIn        (rsRead),
        .rtIn        (rtRead),
        .aluOp       (aluOp),
        .invA        (invA),
        .invB        (invB),
        .cin         (cin),
        .bSrc        (bSrc),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .branch      (branch),
        .halt        (halt),
        .rsData      (rsData),
        .rtData      (rtData),
        .imm5        (imm5),
        .imm8        (imm8),
        .simm11      (simm11),
        .pcNext      (pcNext),
        .rd          (rdDec),
        .regWrite    (regWriteDec),
        .regSrc      (regSrcDec)
    );

    destPipeline #(
        .pipeDepth (pipeDepth)
    ) destPipeline_i (
        .clk            (clk),
        .reset          (reset),
        .rdIn           (rdDec),
        .regWriteIn     (regWriteDec),
        .regSrcIn       (regSrcDec),
        .rdStages       (rdStages),
        .regWriteStages (regWriteStages),
        .regSrc         (regSrc)
    );

endmodule

/* hw/destPipeline.sv */
// Carries destination, write enable and result source toward write-back
// Stage one is the registered decode result, every stage is visible to hazard logic
`timescale 1ns/1ps

module destPipeline #(
    parameter int pipeDepth = 3
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [cpuPkg::regAddrWidth-1:0]                rdIn,
    input  logic                                           regWriteIn,
    input  cpuPkg::regSrcT                                 regSrcIn,
    output logic [pipeDepth-1:0][cpuPkg::regAddrWidth-1:0] rdStages,
    output logic [pipeDepth-1:0]                           regWriteStages,
    output cpuPkg::regSrcT                                 regSrc
);
    import cpuPkg::*;

    // Stages two up to write-back
    logic [pipeDepth-1:1][regAddrWidth-1:0] rdReg;
    logic [pipeDepth-1:1]                   weReg;
    regSrcT                                 srcReg [pipeDepth-1:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            rdReg <= '0;
            weReg <= '0;
            for (int k = 1; k < pipeDepth; k++) begin
                srcReg[k] <= srcAlu;
            end
        end else begin
            rdReg[1]  <= rdIn;
            weReg[1]  <= regWriteIn;
            srcReg[1] <= regSrcIn;
            for (int k = 2; k < pipeDepth; k++) begin
                rdReg[k]  <= rdReg[k-1];
                weReg[k]  <= weReg[k-1];
                srcReg[k] <= srcReg[k-1];
            end
        end
    end

    assign rdStages       = {rdReg, rdIn};
    assign regWriteStages = {weReg, regWriteIn};
    assign regSrc         = srcReg[pipeDepth-1];

    assert property (@(posedge clk) disable iff (reset) !$isunknown(regWriteStages))
        else $error("unknown write enable in destination pipeline");

endmodule

/* hw/instrControl.sv */
// Main control decoder from the major opcode to combinational control levels
// Unknown opcodes decode as a NOP
`timescale 1ns/1ps

module instrControl (
    input  cpuPkg::opcodeT   opcode,
    output cpuPkg::aluClassT aluClass,
    output cpuPkg::dstSelT   dstSel,
    output logic             regWrite,
    output logic             zeroExt,
    output logic             memRead,
    output logic             memWrite,
    output logic             halt,
    output cpuPkg::bSrcT     bSrc,
    output cpuPkg::regSrcT   regSrc,
    output cpuPkg::branchT   branch
);
    import cpuPkg::*;

    always_comb begin
        // NOP levels unless the opcode says otherwise
        aluClass = classPass;
        dstSel   = dstRd;
        regWrite = 1'b0;
        zeroExt  = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        halt     = 1'b0;
        bSrc     = bReg;
        regSrc   = srcAlu;
        branch   = brNone;

        case (opcode)
            opHalt: begin
                halt = 1'b1;
            end
            opAddi, opSubi, opXori, opAndni: begin
                dstSel   = dstRt;
                regWrite = 1'b1;
                bSrc     = bImm5;
                // Logical immediates are zero-extended
                zeroExt  = (opcode == opXori) || (opcode == opAndni);
                case (opcode)
                    opAddi:  aluClass = classAddi;
                    opSubi:  aluClass = classSubi;
                    opXori:  aluClass = classXori;
                    default: aluClass = classAndni;
                endcase
            end
            opLbi: begin
                dstSel   = dstRs;
                regWrite = 1'b1;
                bSrc     = bImm8;
                regSrc   = srcImm;
            end
            opLd: begin
                aluClass = classAddr;
                dstSel   = dstRt;
                regWrite = 1'b1;
                memRead  = 1'b1;
                bSrc     = bImm5;
                regSrc   = srcMem;
            end
            opSt: begin
                aluClass = classAddr;
                memWrite = 1'b1;
                bSrc     = bImm5;
            end
            opBeqz: begin
                bSrc   = bImm8;
                branch = brEqz;
            end
            opBnez: begin
                bSrc   = bImm8;
                branch = brNez;
            end
            // Displacement comes from simm11
            opJ: begin
                branch = brJump;
            end
            opRrr: begin
                aluClass = classRrr;
                dstSel   = dstRd;
                regWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/regFileBypass.sv */
// Register file with two combinational read ports and one write port
// A read of the register being written returns the write data
`timescale 1ns/1ps

module regFileBypass #(
    parameter int numRegs = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::regAddrWidth-1:0] readSel1,
    input  logic [cpuPkg::regAddrWidth-1:0] readSel2,
    input  logic [cpuPkg::regAddrWidth-1:0] writeSel,
    input  logic [cpuPkg::dataWidth-1:0]    writeData,
    input  logic                            writeEn,
    output logic [cpuPkg::dataWidth-1:0]    readData1,
    output logic [cpuPkg::dataWidth-1:0]    readData2
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Bypass the write port
    assign readData1 = (writeEn && (writeSel == readSel1)) ? writeData : regs[readSel1];
    assign readData2 = (writeEn && (writeSel == readSel2)) ? writeData : regs[readSel2];

    // Write-back address from the destination pipeline must be known
    assert property (@(posedge clk) disable iff (reset)
        writeEn |-> !$isunknown(writeSel))
        else $error("register file write with unknown address");

endmodule

/* testbench/clockGen.sv */
// Free-running testbench clock that starts low
`timescale 1ns/1ps

module clockGen #(
    parameter int period = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end
endmodule

/* testbench/tb_decodeTop.sv */
// Testbench for the decode stage, random instructions checked against a model of
// control decode, destination pipeline and register file with bypass
`timescale 1ns/1ps

module tb_decodeTop;
    import cpuPkg::*;

    localparam int resetCycles    = 2;
    localparam int directedCycles = 28;
    localparam int randomCount    = 400;
    localparam int drainCycles    = 4;
    localparam int cycleLimit     = 2 * (resetCycles + directedCycles + randomCount + drainCycles);

    logic                          clk;
    logic                          reset;
    logic [dataWidth-1:0]          instr;
    logic [dataWidth-1:0]          pc;
    logic                          nopInsert;
    logic [dataWidth-1:0]          wbData;
    aluOpT                         aluOp;
    logic                          invA;
    logic                          invB;
    logic                          cin;
    bSrcT                          bSrc;
    logic                          memRead;
    logic                          memWrite;
    branchT                        branch;
    logic                          halt;
    logic [dataWidth-1:0]          rsData;
    logic [dataWidth-1:0]          rtData;
    logic [dataWidth-1:0]          imm5;
    logic [dataWidth-1:0]          imm8;
    logic [dataWidth-1:0]          simm11;
    logic [dataWidth-1:0]          pcNext;
    logic [2:0][regAddrWidth-1:0]  rdStages;
    logic [2:0]                    regWriteStages;
    regSrcT                        regSrc;

    // Model state for the last applied instruction
    logic [31:0]             lfsrState;
    int                      errorCount;
    int                      checkCount;
    int                      cycleCount;
    string                   expName;
    logic [dataWidth-1:0]    modelRegs [8];
    logic [regAddrWidth-1:0] expRd [3];
    logic [2:0]              expWe;
    regSrcT                  expSrc [3];
    aluOpT                   expAluOp;
    logic                    expInvA;
    logic                    expInvB;
    logic                    expCin;
    bSrcT                    expBSrc;
    logic                    expMemRead;
    logic                    expMemWrite;
    branchT                  expBranch;
    logic                    expHalt;
    logic [dataWidth-1:0]    expRsData;
    logic [dataWidth-1:0]    expRtData;
    logic [dataWidth-1:0]    expImm5;
    logic [dataWidth-1:0]    expImm8;
    logic [dataWidth-1:0]    expSimm11;
    logic [dataWidth-1:0]    expPc;

    clockGen #(
        .period (4)
    ) clockGen_i (
        .clk (clk)
    );

    decodeTop #(
        .pipeDepth (3),
        .numRegs   (8)
    ) decodeTop_i (
        .clk            (clk),
        .reset          (reset),
        .instr          (instr),
        .pc             (pc),
        .nopInsert      (nopInsert),
        .wbData         (wbData),
        .aluOp          (aluOp),
        .invA           (invA),
        .invB           (invB),
        .cin            (cin),
        .bSrc           (bSrc),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .branch         (branch),
        .halt           (halt),
        .rsData         (rsData),
        .rtData         (rtData),
        .imm5           (imm5),
        .imm8           (imm8),
        .simm11         (simm11),
        .pcNext         (pcNext),
        .rdStages       (rdStages),
        .regWriteStages (regWriteStages),
        .regSrc         (regSrc)
    );

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic stepLfsr();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], stepLfsr()};
        end
        return value;
    endfunction

    // Supported opcodes with extra weight on register-register
    function automatic opcodeT opFromIndex(input logic [3:0] idx);
        case (idx)
            4'd0:    return opHalt;
            4'd1:    return opNop;
            4'd2:    return opAddi;
            4'd3:    return opSubi;
            4'd4:    return opXori;
            4'd5:    return opAndni;
            4'd6:    return opLbi;
            4'd7:    return opLd;
            4'd8:    return opSt;
            4'd9:    return opBeqz;
            4'd10:   return opBnez;
            4'd11:   return opJ;
            default: return opRrr;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s %s: expected %h, actual %h", expName, name, expected, actual);
        end
    endtask

    // Predicts the controls of one instruction and stage one of the destination model
    task automatic predictDecode(input logic [dataWidth-1:0] ins);
        opcodeT op;
        logic   zext;
        op          = opcodeT'(ins[15:11]);
        zext        = 1'b0;
        expAluOp    = aluPass;
        expInvA     = 1'b0;
        expInvB     = 1'b0;
        expCin      = 1'b0;
        expBSrc     = bReg;
        expMemRead  = 1'b0;
        expMemWrite = 1'b0;
        expBranch   = brNone;
        expHalt     = 1'b0;
        expWe[0]    = 1'b0;
        expRd[0]    = ins[4:2];
        expSrc[0]   = srcAlu;
        case (op)
            opHalt: expHalt = 1'b1;
            opAddi, opSubi, opXori, opAndni: begin
                expWe[0] = 1'b1;
                expRd[0] = ins[7:5];
                expBSrc  = bImm5;
                case (op)
                    opAddi: expAluOp = aluAdd;
                    opSubi: begin
                        expAluOp = aluAdd;
                        expInvA  = 1'b1;
                        expCin   = 1'b1;
                    end
                    opXori: begin
                        expAluOp = aluXor;
                        zext     = 1'b1;
                    end
                    default: begin
                        expAluOp = aluAnd;
                        expInvB  = 1'b1;
                        zext     = 1'b1;
                    end
                endcase
            end
            opLbi: begin
                expWe[0]  = 1'b1;
                expRd[0]  = ins[10:8];
                expBSrc   = bImm8;
                expSrc[0] = srcImm;
            end
            opLd: begin
                expAluOp   = aluAdd;
                expMemRead = 1'b1;
                expWe[0]   = 1'b1;
                expRd[0]   = ins[7:5];
                expBSrc    = bImm5;
                expSrc[0]  = srcMem;
            end
            opSt: begin
                expAluOp    = aluAdd;
                expMemWrite = 1'b1;
                expBSrc     = bImm5;
            end
            opBeqz: begin
                expBSrc   = bImm8;
                expBranch = brEqz;
            end
            opBnez: begin
                expBSrc   = bImm8;
                expBranch = brNez;
            end
            opJ: expBranch = brJump;
            opRrr: begin
                expWe[0] = 1'b1;
                // Function field selects add, sub, xor or andn
                case (ins[1:0])
                    2'b00: expAluOp = aluAdd;
                    2'b01: begin
                        expAluOp = aluAdd;
                        expInvA  = 1'b1;
                        expCin   = 1'b1;
                    end
                    2'b10: expAluOp = aluXor;
                    default: begin
                        expAluOp = aluAnd;
                        expInvB  = 1'b1;
                    end
                endcase
            end
            default: begin
            end
        endcase
        expImm5   = zext ? {11'd0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
        expImm8   = zext ? {8'd0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
        expSimm11 = {{5{ins[10]}}, ins[10:0]};
    endtask

    // Register reads and write-back happen on the same edge as the decode
    task automatic advanceModel(input logic [dataWidth-1:0] instrIn,
                                input logic [dataWidth-1:0] pcIn, input logic nopIn,
                                input logic [dataWidth-1:0] wbIn);
        logic [dataWidth-1:0]    ins;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        ins = nopIn ? {opNop, 11'd0} : instrIn;
        rs  = ins[10:8];
        rt  = ins[7:5];
        expRsData = (expWe[2] && expRd[2] == rs) ? wbIn : modelRegs[rs];
        expRtData = (expWe[2] && expRd[2] == rt) ? wbIn : modelRegs[rt];
        if (expWe[2]) begin
            modelRegs[expRd[2]] = wbIn;
        end
        for (int k = 2; k > 0; k--) begin
            expRd[k]  = expRd[k-1];
            expWe[k]  = expWe[k-1];
            expSrc[k] = expSrc[k-1];
        end
        predictDecode(ins);
        expPc = pcIn;
    endtask

    task automatic checkOutputs();
        checkValue("aluOp", 16'(expAluOp), 16'(aluOp));
        checkValue("invA", 16'(expInvA), 16'(invA));
        checkValue("invB", 16'(expInvB), 16'(invB));
        checkValue("cin", 16'(expCin), 16'(cin));
        checkValue("bSrc", 16'(expBSrc), 16'(bSrc));
        checkValue("memRead", 16'(expMemRead), 16'(memRead));
        checkValue("memWrite", 16'(expMemWrite), 16'(memWrite));
        checkValue("branch", 16'(expBranch), 16'(branch));
        checkValue("halt", 16'(expHalt), 16'(halt));
        checkValue("rsData", expRsData, rsData);
        checkValue("rtData", expRtData, rtData);
        checkValue("imm5", expImm5, imm5);
        checkValue("imm8", expImm8, imm8);
        checkValue("simm11", expSimm11, simm11);
        checkValue("pcNext", expPc, pcNext);
        checkValue("regWriteStages", 16'(expWe), 16'(regWriteStages));
        checkValue("regSrc", 16'(expSrc[2]), 16'(regSrc));
        // Destination only matters where the stage writes
        for (int k = 0; k < 3; k++) begin
            if (expWe[k]) begin
                checkValue($sformatf("rdStages[%0d]", k), 16'(expRd[k]), 16'(rdStages[k]));
            end
        end
    endtask

    // Called just after a falling edge, returns at the next one
    task automatic applyCycle(input logic [dataWidth-1:0] instrIn, input logic nopIn,
                              input string name);
        logic [31:0] rnd;
        checkOutputs();
        rnd       = randBits(32);
        instr     = instrIn;
        nopInsert = nopIn;
        pc        = rnd[15:0];
        wbData    = rnd[31:16];
        advanceModel(instrIn, rnd[15:0], nopIn, rnd[31:16]);
        expName = name;
        @(negedge clk);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]             rnd;
        logic [regAddrWidth-1:0] r;
        opcodeT                  op;
        lfsrState  = 32'hd2cb_2828;
        errorCount = 0;
        checkCount = 0;
        reset      = 1'b1;
        instr      = {opNop, 11'd0};
        pc         = '0;
        nopInsert  = 1'b0;
        wbData     = '0;
        for (int k = 0; k < 8; k++) begin
            modelRegs[k] = '0;
        end
        for (int k = 0; k < 3; k++) begin
            expRd[k]  = '0;
            expSrc[k] = srcAlu;
        end
        expWe = '0;
        predictDecode({opNop, 11'd0});
        expAluOp  = aluAdd;
        expPc     = '0;
        expRsData = '0;
        expRtData = '0;
        expName   = "reset";
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Every register reads back zero
        for (int k = 0; k < 4; k++) begin
            r = {k[1:0], 1'b0};
            applyCycle({opNop, r, r + 3'd1, 5'd0}, 1'b0, "resetRead");
        end

        // Forced NOP hides HALT and LD, an unforced HALT shows
        rnd = randBits(11);
        applyCycle({opHalt, rnd[10:0]}, 1'b1, "nopInsert");
        applyCycle({opHalt, rnd[10:0]}, 1'b0, "halt");
        applyCycle({opLd, rnd[10:0]}, 1'b1, "nopInsert");
        applyCycle({opHalt, rnd[10:0]}, 1'b1, "nopInsert");

        // Reader lands on the write-back cycle, then reads the stored value
        for (int k = 0; k < 4; k++) begin
            r   = {k[1:0], 1'b1};
            rnd = randBits(11);
            applyCycle({opAddi, rnd[10:8], r, rnd[4:0]}, 1'b0, "bypass");
            applyCycle({opNop, 11'd0}, 1'b0, "bypass");
            applyCycle({opNop, 11'd0}, 1'b0, "bypass");
            applyCycle({opRrr, r, r, rnd[4:0]}, 1'b0, "bypass");
            applyCycle({opNop, r, r, 5'd0}, 1'b0, "stored");
        end

        for (int i = 0; i < randomCount; i++) begin
            rnd = randBits(4);
            op  = opFromIndex(rnd[3:0]);
            rnd = randBits(14);
            applyCycle({op, rnd[10:0]}, rnd[13:11] == 3'd0, "random");
        end

        // Let the last writes retire
        for (int i = 0; i < drainCycles; i++) begin
            applyCycle({opNop, 11'd0}, 1'b0, "drain");
        end
        checkOutputs();

        $display("Summary: %0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
